// File: best_route.f
+incdir+src
src/route_mem_pkg.sv
src/fixed_point_pkg.sv
src/node_memory.sv
src/min_q_scan.sv
src/hcm_scale.sv
src/best_route.sv
tests/best_route_properties.sv
tests/best_route_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module best_route_tb -f best_route.f -Mdir obj_dir
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit "$status"
fi

./obj_dir/Vbest_route_tb
status=$?
if [ "$status" -ne 0 ]; then
	echo "simulation failed with status $status"
	exit "$status"
fi

exit 0

// File: tests/best_route_tb.sv
`default_nettype none

`include "best_route_macros.svh"

module best_route_tb;

	localparam int DONE_TIMEOUT = 200; // cycles from start
	localparam int MAX_NEIGHBORS = 8;

	logic clock;
	logic nrst;
	logic start;
	fixed_point_pkg::battery_t battery;
	logic wr_en;
	route_mem_pkg::addr_t wr_addr;
	route_mem_pkg::word_t wr_data;
	fixed_point_pkg::q_value_t best_cost;
	logic done;

	logic [15:0] q_values [0:MAX_NEIGHBORS-1]; // what the node memory holds
	logic [15:0] hcm_table [0:`HCM_LENGTH-1];
	int neighbor_n;
	logic [15:0] last_cost; // best_cost must hold this until the next done

	best_route UUT (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.battery(battery),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.best_cost(best_cost),
		.done(done)
	);

	bind best_route best_route_properties props (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.done(done)
	);

	always #10 clock = ~clock;

	// min of the q-values from the sentinel, times the entry at ceil(10 * battery)
	function automatic logic [15:0] expected_cost(input logic [15:0] batt);
		logic [15:0] best;
		logic [63:0] tenfold;
		logic [63:0] index;
		logic [63:0] product;
		int i;
		best = fixed_point_pkg::BEST_SENTINEL;
		for (i = 0; i < neighbor_n; i++) begin
			if (q_values[i] < best) begin
				best = q_values[i];
			end
		end
		tenfold = {48'd0, batt} * 64'd10; // 17.15
		index = tenfold >> 15;
		if (tenfold[14:0] != 15'd0) begin
			index = index + 64'd1;
		end
		if (index > 64'(`HCM_LENGTH - 1)) begin
			index = 64'(`HCM_LENGTH - 1);
		end
		product = {48'd0, best} * {48'd0, hcm_table[index[3:0]]}; // 14.18
		return product[28:13];
	endfunction

	task automatic report_failure(input string what);
		$display("%s", what);
		$display("=== FAIL ===");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic write_word(input route_mem_pkg::addr_t addr, input route_mem_pkg::word_t data);
		@(negedge clock);
		wr_en = 1'b1;
		wr_addr = addr;
		wr_data = data;
	endtask

	task automatic load_table();
		int i;
		for (i = 0; i < `HCM_LENGTH; i++) begin
			write_word(route_mem_pkg::HCM_BASE_ADDR + 16'(2 * i), hcm_table[i]);
		end
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	task automatic load_node(input int n);
		int i;
		neighbor_n = n;
		write_word(route_mem_pkg::NEIGHBOR_COUNT_ADDR, 16'(n));
		for (i = 0; i < n; i++) begin
			write_word(route_mem_pkg::Q_BASE_ADDR + 16'(2 * i), q_values[i]);
		end
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	task automatic wait_for_done();
		int cycles;
		cycles = 0;
		while (done !== 1'b1) begin
			assert (best_cost == last_cost) else report_failure($sformatf(
				"Error at time %0t: best_cost expected 0x%04h, actual 0x%04h",
				$time, last_cost, best_cost));
			if (cycles >= DONE_TIMEOUT) begin
				report_failure($sformatf("done never came within %0d cycles", DONE_TIMEOUT));
			end
			@(negedge clock);
			cycles++;
		end
	endtask

	task automatic check_result(input fixed_point_pkg::battery_t batt);
		logic [15:0] expected;
		expected = expected_cost(batt);
		assert (best_cost == expected) else report_failure($sformatf(
			"Error at time %0t: best_cost expected 0x%04h, actual 0x%04h",
			$time, expected, best_cost));
		last_cost = best_cost;
	endtask

	task automatic run_and_check(input fixed_point_pkg::battery_t batt);
		@(negedge clock);
		battery = batt;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		wait_for_done();
		check_result(batt);
	endtask

	// start one cycle after done, q writes stay two words ahead of the scan
	task automatic restart_with_reload(input fixed_point_pkg::battery_t batt);
		int i;
		for (i = 0; i < neighbor_n; i++) begin
			write_word(route_mem_pkg::Q_BASE_ADDR + 16'(2 * i), q_values[i]);
			start = (i == 0);
			battery = batt;
		end
		@(negedge clock);
		wr_en = 1'b0;
	endtask

	initial begin
		int round;
		int i;
		clock = 1'b0;
		nrst = 1'b0;
		start = 1'b0;
		battery = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		last_cost = '0;
		neighbor_n = 0;
		void'($urandom(44));
		repeat (8) @(negedge clock);
		nrst = 1'b1;

		for (round = 0; round < 3; round++) begin // random table, battery near half
			for (i = 0; i < `HCM_LENGTH; i++) hcm_table[i] = 16'($urandom);
			for (i = 0; i < MAX_NEIGHBORS; i++) q_values[i] = 16'($urandom);
			load_table();
			load_node(MAX_NEIGHBORS);
			run_and_check(16'h3000 + 16'($urandom % 32'h2000));
		end

		load_node(0); // sentinel gets scaled
		run_and_check(16'($urandom));

		// distinct entries so a one-step index error shows
		for (i = 0; i < `HCM_LENGTH; i++) hcm_table[i] = 16'h2000 + 16'(i * 16'h0400);
		load_table();
		load_node(4);
		run_and_check(16'h0000);
		run_and_check(16'h4000); // exactly 5.0
		run_and_check(16'h4001); // just above, rounds to 6
		run_and_check(16'hFFFF); // clamped to the last entry

		load_node(MAX_NEIGHBORS);
		run_and_check(16'h2000);
		for (i = 0; i < MAX_NEIGHBORS; i++) q_values[i] = 16'($urandom);
		restart_with_reload(16'h6000);
		wait_for_done();
		check_result(16'h6000);

		$display("=== PASS ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: tests/best_route_properties.sv
`default_nettype none

module best_route_properties #(
	parameter int START_WINDOW = 64 // longest start to done gap allowed
) (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start,
	input wire logic done
);

	logic start_seen;
	logic [7:0] since_start; // saturates at all ones

	always_ff @(posedge clock) begin
		if (!nrst) begin
			start_seen <= 1'b0;
			since_start <= '0;
		end else if (start) begin
			start_seen <= 1'b1;
			since_start <= '0;
		end else if (since_start != 8'hFF) begin
			since_start <= since_start + 8'd1;
		end
	end

	done_low_in_reset: assert property (@(posedge clock) !nrst |=> !done)
		else $error("done was high after a reset cycle");

	done_single_cycle: assert property (@(posedge clock) disable iff (!nrst) done |=> !done)
		else $error("done stayed high for two cycles");

	done_after_start: assert property (@(posedge clock) disable iff (!nrst)
		done |-> start_seen && since_start < 8'(START_WINDOW))
		else $error("done came without a start in the last %0d cycles", START_WINDOW);

endmodule

`default_nettype wire

// File: src/best_route.sv
`default_nettype none

module best_route (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start,
	input fixed_point_pkg::battery_t battery,
	input wire logic wr_en,
	input route_mem_pkg::addr_t wr_addr,
	input route_mem_pkg::word_t wr_data,
	output fixed_point_pkg::q_value_t best_cost,
	output logic done
);

	route_mem_pkg::addr_t scan_addr;
	route_mem_pkg::word_t scan_data;
	route_mem_pkg::addr_t hcm_addr;
	route_mem_pkg::word_t hcm_data;
	fixed_point_pkg::q_value_t best_q;
	logic best_valid;

	node_memory u_mem (
		.clock(clock),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.rd_addr_a(scan_addr), // port a serves the scan
		.rd_data_a(scan_data),
		.rd_addr_b(hcm_addr), // port b serves the table lookup
		.rd_data_b(hcm_data)
	);

	min_q_scan u_scan (
		.clock(clock),
		.nrst(nrst),
		.start(start),
		.scan_addr(scan_addr),
		.scan_data(scan_data),
		.best_q(best_q),
		.best_valid(best_valid)
	);

	hcm_scale u_scale (
		.clock(clock),
		.nrst(nrst),
		.best_valid(best_valid),
		.best_q(best_q),
		.battery(battery),
		.hcm_addr(hcm_addr),
		.hcm_data(hcm_data),
		.best_cost(best_cost),
		.done(done)
	);

endmodule

`default_nettype wire

// File: src/hcm_scale.sv
`default_nettype none

`include "best_route_macros.svh"

module hcm_scale (
	input wire logic clock,
	input wire logic nrst,
	input wire logic best_valid,
	input fixed_point_pkg::q_value_t best_q,
	input fixed_point_pkg::battery_t battery,
	output route_mem_pkg::addr_t hcm_addr,
	input route_mem_pkg::word_t hcm_data,
	output fixed_point_pkg::q_value_t best_cost,
	output logic done
);

	// full charge maps onto the last table entry
	localparam int INDEX_LAST = `HCM_LENGTH - 1;
	localparam int TRUNC_LSB = fixed_point_pkg::HCM_FRAC_BITS;
	localparam int TRUNC_MSB = TRUNC_LSB + `WORD_WIDTH - 1;

	logic valid_1;
	logic valid_2;
	logic valid_3;

	logic [31:0] battery_x10; // 17.15
	fixed_point_pkg::q_value_t q_1;
	fixed_point_pkg::q_value_t q_2;
	fixed_point_pkg::q_value_t q_3;

	logic [17:0] index_rounded;
	fixed_point_pkg::hcm_index_t index_clamped;
	fixed_point_pkg::hcm_t hcm_entry;
	logic [31:0] product; // 14.18

	// round up on any fraction, then clamp to the table
	always_comb begin
		index_rounded = {1'b0, battery_x10[31:fixed_point_pkg::BATT_FRAC_BITS]}
			+ 18'(|battery_x10[fixed_point_pkg::BATT_FRAC_BITS-1:0]);
		if (index_rounded > 18'(INDEX_LAST)) begin
			index_clamped = fixed_point_pkg::hcm_index_t'(INDEX_LAST);
		end else begin
			index_clamped = fixed_point_pkg::hcm_index_t'(index_rounded);
		end
	end

	assign hcm_entry = fixed_point_pkg::hcm_t'(hcm_data); // arrives with valid_3
	assign product = 32'(q_3) * 32'(hcm_entry);

	always_ff @(posedge clock) begin
		if (!nrst) begin
			valid_1 <= 1'b0;
			valid_2 <= 1'b0;
			valid_3 <= 1'b0;
			done <= 1'b0;
			best_cost <= '0;
		end else begin
			valid_1 <= best_valid;
			valid_2 <= valid_1;
			valid_3 <= valid_2;
			done <= valid_3;
			if (valid_3) begin
				best_cost <= product[TRUNC_MSB:TRUNC_LSB]; // back to 11.5
			end
		end
	end

	// payload moves only with its valid bit
	always_ff @(posedge clock) begin
		if (best_valid) begin
			battery_x10 <= 32'(battery) * 32'(INDEX_LAST);
			q_1 <= best_q;
		end
		if (valid_1) begin
			hcm_addr <= route_mem_pkg::HCM_BASE_ADDR
				+ route_mem_pkg::addr_t'(index_clamped) * route_mem_pkg::ADDR_STRIDE;
			q_2 <= q_1;
		end
		if (valid_2) begin
			q_3 <= q_2; // waits for the table read
		end
	end

endmodule

`default_nettype wire

// File: src/min_q_scan.sv
`default_nettype none

module min_q_scan (
	input wire logic clock,
	input wire logic nrst,
	input wire logic start,
	output route_mem_pkg::addr_t scan_addr,
	input route_mem_pkg::word_t scan_data,
	output fixed_point_pkg::q_value_t best_q,
	output logic best_valid
);

	typedef enum logic [1:0] {
		S_IDLE,
		S_COUNT,
		S_STREAM,
		S_REPORT
	} state_t;

	state_t state;
	logic count_wait; // count word still in flight from memory

	route_mem_pkg::word_t neighbor_count;
	route_mem_pkg::word_t neighbor_index; // q-value now on scan_data
	fixed_point_pkg::q_value_t best;

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state <= S_IDLE;
			count_wait <= 1'b0;
		end else begin
			case (state)
				S_IDLE: begin
					if (start) begin // a start while busy never reaches here
						state <= S_COUNT;
						count_wait <= 1'b1;
					end
				end
				S_COUNT: begin
					count_wait <= 1'b0;
					if (!count_wait) begin
						if (scan_data == '0) begin
							state <= S_REPORT; // no neighbors, report sentinel
						end else begin
							state <= S_STREAM;
						end
					end
				end
				S_STREAM: begin
					if (neighbor_index == neighbor_count - 16'd1) begin
						state <= S_REPORT; // last q-value being compared
					end
				end
				S_REPORT: begin
					state <= S_IDLE;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// address runs one word ahead of scan_data
	always_ff @(posedge clock) begin
		case (state)
			S_IDLE: begin
				if (start) begin
					scan_addr <= route_mem_pkg::NEIGHBOR_COUNT_ADDR;
					best <= fixed_point_pkg::BEST_SENTINEL;
				end
			end
			S_COUNT: begin
				if (count_wait) begin
					scan_addr <= route_mem_pkg::Q_BASE_ADDR; // first q-value
				end else begin
					neighbor_count <= scan_data;
					neighbor_index <= '0;
					scan_addr <= scan_addr + route_mem_pkg::ADDR_STRIDE;
				end
			end
			S_STREAM: begin
				if (fixed_point_pkg::q_value_t'(scan_data) < best) begin
					best <= fixed_point_pkg::q_value_t'(scan_data);
				end
				neighbor_index <= neighbor_index + 16'd1;
				scan_addr <= scan_addr + route_mem_pkg::ADDR_STRIDE;
			end
			default: begin
			end
		endcase
	end

	assign best_q = best;
	assign best_valid = (state == S_REPORT); // single cycle, report lasts one clock

endmodule

`default_nettype wire

// File: src/node_memory.sv
`default_nettype none

`include "best_route_macros.svh"

module node_memory (
	input wire logic clock,
	input wire logic wr_en,
	input route_mem_pkg::addr_t wr_addr,
	input route_mem_pkg::word_t wr_data,
	input route_mem_pkg::addr_t rd_addr_a,
	output route_mem_pkg::word_t rd_data_a,
	input route_mem_pkg::addr_t rd_addr_b,
	output route_mem_pkg::word_t rd_data_b
);

	localparam int INDEX_WIDTH = $clog2(`MEM_WORDS);

	route_mem_pkg::word_t mem [0:`MEM_WORDS-1];

	logic [INDEX_WIDTH-1:0] wr_index;
	logic [INDEX_WIDTH-1:0] rd_index_a;
	logic [INDEX_WIDTH-1:0] rd_index_b;

	// byte address to word index, bit 0 is always zero
	assign wr_index = wr_addr[INDEX_WIDTH:1];
	assign rd_index_a = rd_addr_a[INDEX_WIDTH:1];
	assign rd_index_b = rd_addr_b[INDEX_WIDTH:1];

	// both read ports registered, a read during a write sees the old word
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_index] <= wr_data;
		end
		rd_data_a <= mem[rd_index_a]; // scan port
		rd_data_b <= mem[rd_index_b]; // table port
	end

endmodule

`default_nettype wire

// File: src/fixed_point_pkg.sv
`default_nettype none

`include "best_route_macros.svh"

package fixed_point_pkg;

	typedef logic [`WORD_WIDTH-1:0] q_value_t; // unsigned 11.5 cost
	typedef logic [`WORD_WIDTH-1:0] battery_t; // unsigned 1.15 fraction of full charge
	typedef logic [`WORD_WIDTH-1:0] hcm_t; // unsigned 3.13 multiplier

	typedef logic [$clog2(`HCM_LENGTH)-1:0] hcm_index_t;

	localparam int BATT_FRAC_BITS = 15;
	localparam int HCM_FRAC_BITS = 13; // dropped again after the multiply

	// running minimum starts here, also the result with no neighbors
	localparam q_value_t BEST_SENTINEL = 16'hFFFE;

endpackage

`default_nettype wire

// File: src/route_mem_pkg.sv
`default_nettype none

`include "best_route_macros.svh"

package route_mem_pkg;

	typedef logic [`WORD_WIDTH-1:0] word_t; // one memory word
	typedef logic [`WORD_WIDTH-1:0] addr_t; // byte address, always even

	// byte address map of the node memory
	localparam addr_t NEIGHBOR_COUNT_ADDR = 16'h068A;
	localparam addr_t Q_BASE_ADDR = 16'h01C8; // one q-value per neighbor
	localparam addr_t HCM_BASE_ADDR = 16'h0648; // heat-cost multiplier table

	localparam addr_t ADDR_STRIDE = 16'd2; // bytes per word

endpackage

`default_nettype wire

// File: src/best_route_macros.svh
`ifndef BEST_ROUTE_MACROS_SVH
`define BEST_ROUTE_MACROS_SVH

// data and address word width
`define WORD_WIDTH 16

// entries in the heat-cost multiplier table
`define HCM_LENGTH 11

// node memory depth in words
`define MEM_WORDS 1024

`endif
